/* core_pkg.sv */
`default_nettype none

package core_pkg;

  // Data path and program memory sizes
  localparam int word_width      = 16;
  localparam int prog_addr_width = 8;

  // Stack depths
  localparam int dstack_depth = 8;
  localparam int cstack_depth = 4;
  localparam int lstack_depth = 2;

  typedef logic [word_width-1:0]      word_t;
  typedef logic [prog_addr_width-1:0] prog_addr_t;

  // One counted loop, from the body's first address through its last one
  typedef struct packed {
    prog_addr_t begin_addr;
    prog_addr_t end_addr;
    word_t      count;
    word_t      index;
  } loop_frame_t;

endpackage

`default_nettype wire

/* core_top.sv */
`default_nettype none
`timescale 1ns/1ps

module core_top (
  input  logic                 clk,
  input  logic                 reset,
  output core_pkg::prog_addr_t prog_addr,
  input  logic [7:0]           prog_data,
  output core_pkg::word_t      out_data,
  output logic                 out_valid,
  output logic                 halted
);
  import core_pkg::*;
  import isa_pkg::*;

  instr_u instr;
  ctrl_t  ctrl;
  word_t  top;
  word_t  second;
  word_t  next_top;

  assign instr = prog_data;

  instr_decode u_decode (
    .instr (instr),
    .ctrl  (ctrl)
  );

  data_stack u_dstack (
    .clk      (clk),
    .reset    (reset),
    .move     (ctrl.stack_move),
    .next_top (next_top),
    .top      (top),
    .second   (second)
  );

  execute u_execute (
    .clk       (clk),
    .reset     (reset),
    .ctrl      (ctrl),
    .top       (top),
    .second    (second),
    .next_top  (next_top),
    .out_data  (out_data),
    .out_valid (out_valid)
  );

  flow_control u_flow (
    .clk       (clk),
    .reset     (reset),
    .ctrl      (ctrl),
    .top       (top),
    .second    (second),
    .prog_addr (prog_addr),
    .halted    (halted)
  );

endmodule

`default_nettype wire

/* data_stack.sv */
`default_nettype none
`timescale 1ns/1ps

module data_stack (
  input  logic                 clk,
  input  logic                 reset,
  input  isa_pkg::stack_move_e move,
  input  core_pkg::word_t      next_top,
  output core_pkg::word_t      top,
  output core_pkg::word_t      second
);
  import core_pkg::*;
  import isa_pkg::*;

  word_t mem [dstack_depth];

  // Number of entries held, so the top lives just below it
  logic [$clog2(dstack_depth):0]   ptr;
  logic [$clog2(dstack_depth)-1:0] push_idx;
  logic [$clog2(dstack_depth)-1:0] top_idx;
  logic [$clog2(dstack_depth)-1:0] second_idx;

  assign push_idx   = ptr[$clog2(dstack_depth)-1:0];
  assign top_idx    = push_idx - 1'b1;
  assign second_idx = push_idx - 2'd2;
  assign top        = mem[top_idx];
  assign second     = mem[second_idx];

  always_ff @(posedge clk) begin
    if (reset) begin
      ptr <= '0;
    end else begin
      case (move)
        move_push: ptr <= ptr + 1'b1;
        move_pop1: ptr <= ptr - 1'b1;
        move_pop2: ptr <= ptr - 2'd2;
        default:   ptr <= ptr;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    case (move)
      move_push: mem[push_idx] <= next_top;
      // The surviving entry becomes the top and takes the new value
      move_pop1: begin
        if (ptr >= 2) begin
          mem[second_idx] <= next_top;
        end
      end
      // A changed top on hold is an exchange with the entry below it
      move_hold: begin
        if (ptr >= 2 && next_top != top) begin
          mem[top_idx]    <= next_top;
          mem[second_idx] <= top;
        end
      end
      // Pop2 only drops both entries since no opcode pushes after it
      default: ;
    endcase
  end

  a_push_room: assert property (@(posedge clk) disable iff (reset)
    move == move_push |-> ptr < dstack_depth);

  a_pop1_entry: assert property (@(posedge clk) disable iff (reset)
    move == move_pop1 |-> ptr >= 1);

  a_pop2_entries: assert property (@(posedge clk) disable iff (reset)
    move == move_pop2 |-> ptr >= 2);

endmodule

`default_nettype wire

/* execute.sv */
`default_nettype none
`timescale 1ns/1ps

module execute (
  input  logic            clk,
  input  logic            reset,
  input  isa_pkg::ctrl_t  ctrl,
  input  core_pkg::word_t top,
  input  core_pkg::word_t second,
  output core_pkg::word_t next_top,
  output core_pkg::word_t out_data,
  output logic            out_valid
);
  import core_pkg::*;
  import isa_pkg::*;

  logic              carry;
  logic              carry_in;
  word_t             addend;
  word_t             alu_result;
  logic [word_width:0] sum;

  // Subtraction adds the inverted top plus one, so the carry out is not-borrow
  always_comb begin
    addend   = (ctrl.alu_op == alu_sub) ? ~top : top;
    carry_in = (ctrl.alu_op == alu_sub) ? 1'b1 : (ctrl.use_carry & carry);
    sum      = {1'b0, second} + {1'b0, addend} + {{word_width{1'b0}}, carry_in};
    case (ctrl.alu_op)
      alu_add, alu_addc, alu_sub: alu_result = sum[word_width-1:0];
      alu_and: alu_result = second & top;
      alu_xor: alu_result = second ^ top;
      default: alu_result = top;
    endcase
  end

  always_comb begin
    case (ctrl.result_sel)
      res_literal: next_top = {{(word_width-lit_width){1'b0}}, ctrl.literal};
      res_alu:     next_top = alu_result;
      res_dup:     next_top = top;
      res_swap:    next_top = second;
      default:     next_top = top;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      carry     <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      if (ctrl.upd_carry) begin
        carry <= sum[word_width];
      end
      out_valid <= ctrl.is_out;
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl.is_out) begin
      out_data <= top;
    end
  end

endmodule

`default_nettype wire

/* flow_control.sv */
`default_nettype none
`timescale 1ns/1ps

module flow_control (
  input  logic                 clk,
  input  logic                 reset,
  input  isa_pkg::ctrl_t       ctrl,
  input  core_pkg::word_t      top,
  input  core_pkg::word_t      second,
  output core_pkg::prog_addr_t prog_addr,
  output logic                 halted
);
  import core_pkg::*;
  import isa_pkg::*;

  prog_addr_t  pc;
  prog_addr_t  pc_next;
  prog_addr_t  pc_plus1;

  // Return addresses
  prog_addr_t                      cstack [cstack_depth];
  logic [$clog2(cstack_depth):0]   csp;
  logic [$clog2(cstack_depth)-1:0] csp_idx;
  logic [$clog2(cstack_depth)-1:0] ret_idx;

  // Active loop and the frames of the loops around it
  loop_frame_t                     frame;
  logic                            loop_active;
  loop_frame_t                     lstack [lstack_depth];
  logic [$clog2(lstack_depth):0]   lsp;
  logic [$clog2(lstack_depth)-1:0] lsp_idx;
  logic [$clog2(lstack_depth)-1:0] restore_idx;

  logic stop;
  logic branch_taken;
  logic loop_step;
  logic at_end;
  logic last_iter;
  logic loop_exit;
  logic loop_repeat;

  assign pc_plus1    = pc + 1'b1;
  assign csp_idx     = csp[$clog2(cstack_depth)-1:0];
  assign ret_idx     = csp_idx - 1'b1;
  assign lsp_idx     = lsp[$clog2(lstack_depth)-1:0];
  assign restore_idx = lsp_idx - 1'b1;

  assign stop         = halted | ctrl.is_halt;
  assign branch_taken = ctrl.is_jmp | ctrl.is_call | (ctrl.is_jz & (second == '0));
  // Loop bookkeeping only advances when nothing ahead of it moved the PC
  assign loop_step    = ~stop & ~ctrl.is_ret & ~branch_taken;
  assign at_end       = loop_active & (pc == frame.end_addr) & ~ctrl.is_loop;
  assign last_iter    = (frame.index + 1'b1) == frame.count;
  assign loop_exit    = loop_active & (ctrl.is_break | (at_end & last_iter));
  assign loop_repeat  = at_end & ~last_iter;

  // The memory is read with the next PC, so its data always matches pc
  always_comb begin
    if (reset) begin
      pc_next = '0;
    end else if (stop) begin
      pc_next = pc;
    end else if (ctrl.is_ret) begin
      pc_next = cstack[ret_idx];
    end else if (branch_taken) begin
      pc_next = top[prog_addr_width-1:0];
    end else if (loop_exit) begin
      pc_next = frame.end_addr + 1'b1;
    end else if (loop_repeat) begin
      pc_next = frame.begin_addr;
    end else begin
      pc_next = pc_plus1;
    end
  end

  assign prog_addr = pc_next;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc          <= '0;
      halted      <= 1'b0;
      csp         <= '0;
      lsp         <= '0;
      loop_active <= 1'b0;
    end else begin
      pc <= pc_next;
      if (ctrl.is_halt) begin
        halted <= 1'b1;
      end
      if (!stop && ctrl.is_call) begin
        csp <= csp + 1'b1;
      end else if (!stop && ctrl.is_ret && csp != '0) begin
        csp <= csp - 1'b1;
      end
      if (loop_step && ctrl.is_loop) begin
        loop_active <= 1'b1;
        if (loop_active) begin
          lsp <= lsp + 1'b1;
        end
      end else if (loop_step && loop_exit) begin
        if (lsp != '0) begin
          lsp <= lsp - 1'b1;
        end else begin
          loop_active <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!stop && ctrl.is_call) begin
      cstack[csp_idx] <= pc_plus1;
    end
    if (loop_step && ctrl.is_loop) begin
      if (loop_active) begin
        lstack[lsp_idx] <= frame;
      end
      frame.begin_addr <= pc_plus1;
      frame.end_addr   <= second[prog_addr_width-1:0];
      frame.count      <= top;
      frame.index      <= '0;
    end else if (loop_step && loop_exit) begin
      if (lsp != '0) begin
        frame <= lstack[restore_idx];
      end
    end else if (loop_step && loop_repeat) begin
      frame.index <= frame.index + 1'b1;
    end
  end

  a_cstack_room: assert property (@(posedge clk) disable iff (reset)
    ctrl.is_call && !halted |-> csp < cstack_depth);

  a_lstack_room: assert property (@(posedge clk) disable iff (reset)
    ctrl.is_loop && !halted && loop_active |-> lsp < lstack_depth);

  a_loop_count: assert property (@(posedge clk) disable iff (reset)
    ctrl.is_loop && !halted |-> top != '0);

endmodule

`default_nettype wire

/* instr_decode.sv */
`default_nettype none
`timescale 1ns/1ps

module instr_decode (
  input  isa_pkg::instr_u instr,
  output isa_pkg::ctrl_t  ctrl
);
  import isa_pkg::*;

  always_comb begin
    // Anything not listed below, unknown opcodes included, behaves as a nop
    ctrl            = '0;
    ctrl.alu_op     = alu_pass;
    ctrl.stack_move = move_hold;
    ctrl.result_sel = res_dup;

    if (instr.lit.is_lit) begin
      ctrl.stack_move = move_push;
      ctrl.result_sel = res_literal;
      ctrl.literal    = instr.lit.value;
    end else begin
      case (instr.op.opcode)
        op_add, op_addc, op_sub, op_and, op_xor: begin
          ctrl.stack_move = move_pop1;
          ctrl.result_sel = res_alu;
          case (instr.op.opcode)
            op_add:  ctrl.alu_op = alu_add;
            op_addc: ctrl.alu_op = alu_addc;
            op_sub:  ctrl.alu_op = alu_sub;
            op_and:  ctrl.alu_op = alu_and;
            default: ctrl.alu_op = alu_xor;
          endcase
          ctrl.upd_carry = instr.op.opcode inside {op_add, op_addc, op_sub};
          ctrl.use_carry = instr.op.opcode == op_addc;
        end
        op_dup:  ctrl.stack_move = move_push;
        // A plain swap keeps the depth and takes second as the new top
        op_swap: ctrl.result_sel = res_swap;
        op_drop, op_out, op_jmp, op_call: begin
          ctrl.stack_move = move_pop1;
          ctrl.result_sel = res_swap;
          ctrl.is_out     = instr.op.opcode == op_out;
          ctrl.is_jmp     = instr.op.opcode == op_jmp;
          ctrl.is_call    = instr.op.opcode == op_call;
        end
        op_jz, op_loop: begin
          ctrl.stack_move = move_pop2;
          ctrl.is_jz      = instr.op.opcode == op_jz;
          ctrl.is_loop    = instr.op.opcode == op_loop;
        end
        op_ret:   ctrl.is_ret = 1'b1;
        op_break: ctrl.is_break = 1'b1;
        op_halt:  ctrl.is_halt = 1'b1;
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

/* isa_pkg.sv */
`default_nettype none

package isa_pkg;

  localparam int lit_width = 7;

  typedef enum logic [6:0] {
    op_nop   = 7'd0,
    op_add   = 7'd1,
    op_addc  = 7'd2,
    op_sub   = 7'd3,
    op_and   = 7'd4,
    op_xor   = 7'd5,
    op_dup   = 7'd6,
    op_drop  = 7'd7,
    op_swap  = 7'd8,
    op_out   = 7'd9,
    op_jmp   = 7'd10,
    op_jz    = 7'd11,
    op_call  = 7'd12,
    op_ret   = 7'd13,
    op_loop  = 7'd14,
    op_break = 7'd15,
    op_halt  = 7'd16
  } opcode_e;

  // With the top bit set the byte is a literal to push, otherwise an opcode
  typedef struct packed {
    logic                 is_lit;
    logic [lit_width-1:0] value;
  } lit_view_t;

  typedef struct packed {
    logic    is_lit;
    opcode_e opcode;
  } op_view_t;

  typedef union packed {
    lit_view_t lit;
    op_view_t  op;
  } instr_u;

  typedef enum logic [2:0] {
    alu_pass,
    alu_add,
    alu_addc,
    alu_sub,
    alu_and,
    alu_xor
  } alu_op_e;

  typedef enum logic [1:0] {
    move_hold,
    move_push,
    move_pop1,
    move_pop2
  } stack_move_e;

  // Source of the word written as the new top of the data stack
  typedef enum logic [1:0] {
    res_literal,
    res_alu,
    res_dup,
    res_swap
  } result_sel_e;

  typedef struct packed {
    alu_op_e              alu_op;
    logic                 upd_carry;
    logic                 use_carry;
    stack_move_e          stack_move;
    result_sel_e          result_sel;
    logic [lit_width-1:0] literal;
    logic                 is_out;
    logic                 is_jmp;
    logic                 is_jz;
    logic                 is_call;
    logic                 is_ret;
    logic                 is_loop;
    logic                 is_break;
    logic                 is_halt;
  } ctrl_t;

endpackage

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line in the log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module tb_core \
  -o tb_core_sim && ./obj_dir/tb_core_sim > sim.log 2>&1
cat sim.log
grep -q "^Finished with no errors$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

/* tb_programs.svh */
  // Instruction bytes are built through the two views of the instruction union
  function automatic logic [7:0] lit_byte(input logic [6:0] value);
    instr_u instr;
    instr.lit.is_lit = 1'b1;
    instr.lit.value  = value;
    return instr;
  endfunction

  function automatic logic [7:0] op_byte(input opcode_e opcode);
    instr_u instr;
    instr.op.is_lit = 1'b0;
    instr.op.opcode = opcode;
    return instr;
  endfunction

  // The first byte of the list sits in the most significant position and goes to address 0
  task automatic place_code(input int len, input logic [8*32-1:0] code);
    for (int i = 0; i < len; i++) begin
      prog_mem[i] = code[8*(len-1-i) +: 8];
    end
  endtask

  task automatic expect_words(input int len, input logic [16*16-1:0] words);
    exp_len = len;
    for (int i = 0; i < len; i++) begin
      exp_mem[i] = words[16*(len-1-i) +: 16];
    end
  endtask

  task automatic load_program(input int test_id);
    logic [6:0] r [10];
    word_t      w [10];
    case (test_id)
      1: begin
        for (int i = 0; i < 10; i++) begin
          r[i] = 7'($random(seed));
          w[i] = {9'd0, r[i]};
        end
        // 0 - 1 gives all ones, and adding 1 then overflows into the carry
        place_code(27, {lit_byte(r[0]), lit_byte(r[1]), op_byte(op_add), op_byte(op_out),
          lit_byte(r[2]), lit_byte(r[3]), op_byte(op_sub), op_byte(op_out),
          lit_byte(r[4]), lit_byte(r[5]), op_byte(op_and), op_byte(op_out),
          lit_byte(r[6]), lit_byte(r[7]), op_byte(op_xor), op_byte(op_out),
          lit_byte(7'd0), lit_byte(7'd1), op_byte(op_sub), lit_byte(7'd1), op_byte(op_add),
          op_byte(op_out), lit_byte(r[8]), lit_byte(r[9]), op_byte(op_addc), op_byte(op_out),
          op_byte(op_halt)});
        expect_words(6, {w[0] + w[1], w[2] - w[3], w[4] & w[5], w[6] ^ w[7], 16'd0,
          w[8] + w[9] + 16'd1});
      end
      2: begin
        place_code(19, {lit_byte(7'd5), op_byte(op_dup), op_byte(op_add), op_byte(op_out),
          lit_byte(7'd3), lit_byte(7'd9), op_byte(op_swap), op_byte(op_out), op_byte(op_out),
          lit_byte(7'd7), lit_byte(7'd8), op_byte(op_drop), op_byte(op_out),
          lit_byte(7'd20), lit_byte(7'd6), op_byte(op_swap), op_byte(op_sub), op_byte(op_out),
          op_byte(op_halt)});
        expect_words(5, {16'd10, 16'd3, 16'd9, 16'd7, 16'hfff2});
      end
      3: begin
        // The jmp skips the out at address 3, the first jz is taken and the second one falls
        // through
        place_code(17, {lit_byte(7'd4), op_byte(op_jmp), lit_byte(7'd1), op_byte(op_out),
          lit_byte(7'd2), op_byte(op_out), lit_byte(7'd0), lit_byte(7'd11), op_byte(op_jz),
          lit_byte(7'd3), op_byte(op_out), lit_byte(7'd5), lit_byte(7'd16), op_byte(op_jz),
          lit_byte(7'd6), op_byte(op_out), op_byte(op_halt)});
        expect_words(2, {16'd2, 16'd6});
      end
      4: begin
        // Subroutine at 8 calls a second one at 14
        place_code(17, {lit_byte(7'd1), op_byte(op_out), lit_byte(7'd8), op_byte(op_call),
          lit_byte(7'd4), op_byte(op_out), op_byte(op_halt), op_byte(op_nop),
          lit_byte(7'd2), op_byte(op_out), lit_byte(7'd14), op_byte(op_call), op_byte(op_ret),
          op_byte(op_nop), lit_byte(7'd3), op_byte(op_out), op_byte(op_ret)});
        expect_words(4, {16'd1, 16'd2, 16'd3, 16'd4});
      end
      5: begin
        // Outer body 3..10 runs three times, inner body 8..9 twice per pass, then a break
        place_code(21, {lit_byte(7'd10), lit_byte(7'd3), op_byte(op_loop),
          lit_byte(7'd11), op_byte(op_out), lit_byte(7'd9), lit_byte(7'd2), op_byte(op_loop),
          lit_byte(7'd22), op_byte(op_out), op_byte(op_nop),
          lit_byte(7'd17), lit_byte(7'd5), op_byte(op_loop), lit_byte(7'd33), op_byte(op_out),
          op_byte(op_break), op_byte(op_nop), lit_byte(7'd44), op_byte(op_out),
          op_byte(op_halt)});
        expect_words(11, {16'd11, 16'd22, 16'd22, 16'd11, 16'd22, 16'd22,
          16'd11, 16'd22, 16'd22, 16'd33, 16'd44});
      end
      default: begin
        place_code(6, {lit_byte(7'd7), op_byte(op_out), op_byte(op_halt),
          lit_byte(7'd9), op_byte(op_out), op_byte(op_halt)});
        expect_words(1, {16'd7});
      end
    endcase
  endtask

/* tb_core.sv */
`default_nettype none
`timescale 1ns/1ps

module tb_core;
  import core_pkg::*;
  import isa_pkg::*;

  localparam int timeout_cycles = 500;
  localparam int num_tests      = 6;

  logic       clk;
  logic       reset;
  prog_addr_t prog_addr;
  logic [7:0] prog_data;
  word_t      out_data;
  logic       out_valid;
  logic       halted;

  logic [7:0] prog_mem [256];
  prog_addr_t read_addr;

  // Expected output words of the running test, in order
  word_t exp_mem [32];
  word_t exp_word;
  int    exp_len;
  int    out_count;

  int err_count;
  int passed;
  int seed;

  core_top dut_i (
    .clk       (clk),
    .reset     (reset),
    .prog_addr (prog_addr),
    .prog_data (prog_data),
    .out_data  (out_data),
    .out_valid (out_valid),
    .halted    (halted)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  // The address is taken on the rising edge and its byte shows up on the falling edge
  always @(posedge clk) begin
    read_addr <= prog_addr;
  end

  always @(negedge clk) begin
    prog_data <= prog_mem[read_addr];
  end

  always @(posedge clk) begin
    if (reset) begin
      out_count <= 0;
    end else if (out_valid) begin
      out_count <= out_count + 1;
    end
  end

  assign exp_word = exp_mem[out_count[4:0]];

  check_out_value: assert property (@(posedge clk) disable iff (reset)
    out_valid && out_count < exp_len |-> out_data == exp_word)
  else begin
    err_count = err_count + 1;
    $display("ERR %0t: out_data is %h, expected %h", $time, $sampled(out_data),
             $sampled(exp_word));
  end

  check_out_count: assert property (@(posedge clk) disable iff (reset)
    out_valid |-> out_count < exp_len)
  else begin
    err_count = err_count + 1;
    $display("At %0t the core sent more output words than the test expects", $time);
  end

  check_quiet_halt: assert property (@(posedge clk) disable iff (reset)
    halted |-> !out_valid)
  else begin
    err_count = err_count + 1;
    $display("At %0t the core raised out_valid while halted", $time);
  end

  check_halt_held: assert property (@(posedge clk) disable iff (reset)
    halted |=> halted)
  else begin
    err_count = err_count + 1;
    $display("At %0t the core left the halted state without a reset", $time);
  end

  check_addr_held: assert property (@(posedge clk) disable iff (reset)
    halted |-> $stable(prog_addr))
  else begin
    err_count = err_count + 1;
    $display("At %0t the program address moved while the core was halted", $time);
  end

  `include "tb_programs.svh"

  task automatic run_test(input int test_id, input string name, input int hold_cycles);
    int errs_before;
    int cycles;
    errs_before = err_count;
    @(negedge clk);
    reset = 1'b1;
    load_program(test_id);
    repeat (4) @(negedge clk);
    reset  = 1'b0;
    cycles = 0;
    while (!halted && cycles < timeout_cycles) begin
      @(negedge clk);
      cycles = cycles + 1;
    end
    if (!halted) begin
      err_count = err_count + 1;
      $display("Test %0d timed out: the core did not halt within %0d cycles", test_id,
               timeout_cycles);
    end
    // Extra cycles let the halt checks watch a stopped core
    repeat (hold_cycles) @(negedge clk);
    if (hold_cycles > 0) begin
      assert (halted)
      else begin
        err_count = err_count + 1;
        $display("Test %0d: halted went low while the core was stopped", test_id);
      end
    end
    assert (out_count == exp_len)
    else begin
      err_count = err_count + 1;
      $display("ERR %0t: test %0d sent %0d output words, expected %0d", $time, test_id,
               out_count, exp_len);
    end
    if (err_count == errs_before) begin
      passed = passed + 1;
      $display("Test %0d %s: passed", test_id, name);
    end else begin
      $display("Test %0d %s: failed with %0d errors", test_id, name,
               err_count - errs_before);
    end
  endtask

  initial begin
    reset     = 1'b1;
    prog_data <= 8'h00;
    read_addr <= '0;
    exp_len   = 0;
    err_count = 0;
    passed    = 0;
    seed      = 72663;
    run_test(1, "arithmetic", 0);
    run_test(2, "stack shuffles", 0);
    run_test(3, "jumps", 0);
    run_test(4, "calls", 0);
    run_test(5, "loops", 0);
    run_test(6, "halt", 20);
    $display("Tests run %0d, passed %0d, failed %0d, errors %0d", num_tests, passed,
             num_tests - passed, err_count);
    if (err_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+.
core_pkg.sv
isa_pkg.sv
instr_decode.sv
data_stack.sv
execute.sv
flow_control.sv
core_top.sv
tb_core.sv
